// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= tb_wbx
FILELIST  ?= src.f
OBJ_DIR   ?= obj_dir

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "^RESULT: PASS$$"

clean:
	rm -rf $(OBJ_DIR)

// File: dv/tb_wbx.sv
// Testbench for the 2x2 Wishbone interconnect with master drivers, memory slaves and checks
`timescale 1ns/1ns
`default_nettype none

module tb_wbx
	import wbx_pkg::*;
;
	// 40 transactions of up to 12 cycles each and twice that for contention
	localparam int CYCLE_LIMIT = 40 * 12 * 2;

	logic clk;
	logic rstn;
	logic [N_MASTERS-1:0]             m_cyc, m_stb, m_we;
	logic [N_MASTERS-1:0][ADDR_W-1:0] m_adr;
	logic [N_MASTERS-1:0][SEL_W-1:0]  m_sel;
	logic [N_MASTERS-1:0][DATA_W-1:0] m_dat_w;
	wire  [N_MASTERS-1:0]             m_ack_o, m_err_o;
	wire  [N_MASTERS-1:0][DATA_W-1:0] m_dat_r_o;
	wire  [N_SLAVES-1:0]              s_cyc_o, s_stb_o, s_we_o;
	wire  [N_SLAVES-1:0][ADDR_W-1:0]  s_adr_o;
	wire  [N_SLAVES-1:0][SEL_W-1:0]   s_sel_o;
	wire  [N_SLAVES-1:0][DATA_W-1:0]  s_dat_w_o;
	wire  [N_SLAVES-1:0]              s_ack, s_err;
	wire  [N_SLAVES-1:0][DATA_W-1:0]  s_dat_r;

	int seed = 32'h1ef1;
	int err_cnt = 0;
	int tx_cnt = 0;
	int cyc_cnt = 0;
	// Expected response of each master's live cycle
	logic [N_MASTERS-1:0]             exp_err;
	logic [N_MASTERS-1:0][DATA_W-1:0] exp_dat;
	// Testbench copy of both slave memories keyed by word address
	logic [31:0] exp_mem [logic [31:0]];
	// Tie tracking for the round-robin checks
	logic tie_on, tie_win;
	logic tie_acked = 1'b0;
	logic started = 1'b0;
	logic [N_SLAVES-1:0]  slv_match;
	logic [N_MASTERS-1:0] ack_owned;

	wbx_interconnect_2x2 dut_i (
		.clk (clk), .rstn (rstn),
		.m_cyc_i (m_cyc), .m_stb_i (m_stb), .m_we_i (m_we), .m_adr_i (m_adr),
		.m_sel_i (m_sel), .m_dat_w_i (m_dat_w),
		.m_ack_o (m_ack_o), .m_err_o (m_err_o), .m_dat_r_o (m_dat_r_o),
		.s_cyc_o (s_cyc_o), .s_stb_o (s_stb_o), .s_we_o (s_we_o), .s_adr_o (s_adr_o),
		.s_sel_o (s_sel_o), .s_dat_w_o (s_dat_w_o),
		.s_ack_i (s_ack), .s_err_i (s_err), .s_dat_r_i (s_dat_r)
	);

	// Contents of a word never written
	function automatic logic [31:0] fill_word(input logic [31:0] a);
		return {a[15:0], a[31:16]} ^ 32'h5a3c_96e1;
	endfunction

	function automatic logic [31:0] merge_bytes(input logic [31:0] old, input logic [31:0] nw,
			input logic [3:0] sel);
		logic [31:0] r;
		r = old;
		for (int b = 0; b < 4; b++) begin
			if (sel[b]) r[b*8 +: 8] = nw[b*8 +: 8];
		end
		return r;
	endfunction

	function automatic logic in_window(input int k, input logic [31:0] a);
		if (k == 0) return a >= SLV0_BASE && a <= SLV0_LIMIT;
		return a >= SLV1_BASE && a <= SLV1_LIMIT;
	endfunction

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	always @(posedge clk) begin
		cyc_cnt <= cyc_cnt + 1;
		if (cyc_cnt >= CYCLE_LIMIT) begin
			$display("Timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
			$display("RESULT: FAIL");
			$finish;
		end
	end

	// Memory slave models with 0 to 3 wait states
	for (genvar k = 0; k < N_SLAVES; k++) begin : g_slv
		logic [31:0] mem [logic [31:0]];
		logic        ack_q = 1'b0;
		logic [31:0] dat_q = '0;
		logic [1:0]  wait_q = '0;
		logic [31:0] word;
		logic [31:0] old;

		always @(posedge clk) begin
			if (!rstn) begin
				ack_q <= 1'b0;
				wait_q <= '0;
			end else if (ack_q) begin
				ack_q <= 1'b0;
				wait_q <= 2'($random(seed));
			end else if (s_cyc_o[k] && s_stb_o[k]) begin
				if (wait_q != 0) begin
					wait_q <= wait_q - 2'd1;
				end else begin
					ack_q <= 1'b1;
					word = {s_adr_o[k][31:2], 2'b00};
					old = mem.exists(word) ? mem[word] : fill_word(word);
					if (s_we_o[k]) begin
						mem[word] = merge_bytes(old, s_dat_w_o[k], s_sel_o[k]);
					end else begin
						dat_q <= old;
					end
				end
			end
		end

		assign s_ack[k] = ack_q;
		assign s_err[k] = 1'b0;
		assign s_dat_r[k] = dat_q;
	end

	// Slave fields must copy a strobing master
	// An ACK needs the master's own slave cycle
	always_comb begin
		slv_match = '0;
		ack_owned = '0;
		for (int k = 0; k < N_SLAVES; k++) begin
			for (int m = 0; m < N_MASTERS; m++) begin
				if (m_cyc[m] && m_stb[m] && s_adr_o[k] == m_adr[m] && s_we_o[k] == m_we[m] &&
						s_sel_o[k] == m_sel[m] && s_dat_w_o[k] == m_dat_w[m])
					slv_match[k] = 1'b1;
				if (s_stb_o[k] && s_adr_o[k] == m_adr[m] && s_we_o[k] == m_we[m])
					ack_owned[m] = 1'b1;
			end
		end
	end

	always @(posedge clk) begin
		if (|m_stb) begin
			started <= 1'b1;
		end
		// Winner flag clears between ties
		if (!tie_on) begin
			tie_acked <= 1'b0;
		end else if (m_ack_o[tie_win]) begin
			tie_acked <= 1'b1;
		end
	end

	// Nothing moves on either side before the first strobe
	a_quiet: assert property (@(posedge clk) disable iff (!rstn)
		!started |-> (s_cyc_o == '0 && s_stb_o == '0 && m_ack_o == '0 && m_err_o == '0))
		else begin
			err_cnt++;
			$display("ERROR %0t: bus active before any strobe", $time);
		end

	// Loser of a tie is only acknowledged after the winner
	a_tie: assert property (@(posedge clk) disable iff (!rstn)
		(tie_on && m_ack_o[!tie_win]) |-> tie_acked)
		else begin
			err_cnt++;
			$display("ERROR %0t: tie won by master %0d", $time, !tie_win);
		end

	for (genvar m = 0; m < N_MASTERS; m++) begin : g_mchk
		a_rdata: assert property (@(posedge clk) disable iff (!rstn)
			(m_ack_o[m] && !m_we[m]) |-> m_dat_r_o[m] == exp_dat[m])
			else begin
				err_cnt++;
				$display("ERROR %0t: master %0d read %h, expected %h", $time, m,
					m_dat_r_o[m], exp_dat[m]);
			end
		a_ack: assert property (@(posedge clk) disable iff (!rstn)
			m_ack_o[m] |-> (!exp_err[m] && ack_owned[m]))
			else begin
				err_cnt++;
				$display("ERROR %0t: bad ACK to master %0d", $time, m);
			end
		a_err: assert property (@(posedge clk) disable iff (!rstn)
			m_err_o[m] |-> (exp_err[m] && !m_ack_o[m]))
			else begin
				err_cnt++;
				$display("ERROR %0t: bad ERR to master %0d", $time, m);
			end
	end

	for (genvar k = 0; k < N_SLAVES; k++) begin : g_schk
		a_window: assert property (@(posedge clk) disable iff (!rstn)
			s_stb_o[k] |-> in_window(k, s_adr_o[k]))
			else begin
				err_cnt++;
				$display("ERROR %0t: slave %0d strobed off window", $time, k);
			end
		a_fields: assert property (@(posedge clk) disable iff (!rstn)
			s_stb_o[k] |-> slv_match[k])
			else begin
				err_cnt++;
				$display("ERROR %0t: slave %0d fields mismatch", $time, k);
			end
	end

	// One classic cycle that drops STB and CYC at the response edge
	task automatic wb_access(input int m, input logic we, input logic [31:0] adr,
			input logic [3:0] sel, input logic [31:0] dat);
		logic [31:0] word;
		logic [31:0] old;
		logic        unmapped;
		word = {adr[31:2], 2'b00};
		unmapped = !(in_window(0, adr) || in_window(1, adr));
		old = exp_mem.exists(word) ? exp_mem[word] : fill_word(word);
		if (we && !unmapped) exp_mem[word] = merge_bytes(old, dat, sel);
		@(posedge clk);
		m_cyc[m] <= 1'b1;
		m_stb[m] <= 1'b1;
		m_we[m] <= we;
		m_adr[m] <= adr;
		m_sel[m] <= sel;
		m_dat_w[m] <= dat;
		exp_err[m] <= unmapped;
		exp_dat[m] <= old;
		do @(posedge clk); while (!(m_ack_o[m] || m_err_o[m]));
		m_cyc[m] <= 1'b0;
		m_stb[m] <= 1'b0;
		tx_cnt++;
		@(posedge clk);
	endtask

	initial begin
		logic [31:0] d0, d1;
		logic [3:0]  s0, s1;
		rstn = 1'b0;
		m_cyc = '0;
		m_stb = '0;
		m_we = '0;
		m_adr = '0;
		m_sel = '0;
		m_dat_w = '0;
		exp_err = '0;
		exp_dat = '0;
		tie_on = 1'b0;
		tie_win = 1'b0;
		repeat (2) @(posedge clk);
		rstn <= 1'b1;
		@(posedge clk);

		// First tie after reset goes to master 0
		tie_win <= 1'b0;
		tie_on <= 1'b1;
		fork
			wb_access(0, 1'b1, SLV0_BASE + 32'h40, 4'hf, 32'h1111_0000);
			wb_access(1, 1'b1, SLV0_BASE + 32'h140, 4'hf, 32'h2222_0000);
		join
		tie_on <= 1'b0;
		// Master 0 owns slave 0 last, so the next tie rotates to master 1
		wb_access(0, 1'b0, SLV0_BASE + 32'h40, 4'hf, 32'h0);
		tie_win <= 1'b1;
		tie_on <= 1'b1;
		fork
			wb_access(0, 1'b0, SLV0_BASE + 32'h40, 4'hf, 32'h0);
			wb_access(1, 1'b0, SLV0_BASE + 32'h140, 4'hf, 32'h0);
		join
		tie_on <= 1'b0;

		// Writes go first to separate slaves in parallel and then cross over
		for (int i = 0; i < 4; i++) begin
			d0 = $random(seed);
			d1 = $random(seed);
			fork
				wb_access(0, 1'b1, SLV0_BASE + 32'(i * 4), 4'hf, d0);
				wb_access(1, 1'b1, SLV1_BASE + 32'h100 + 32'(i * 4), 4'hf, d1);
			join
			d0 = $random(seed);
			d1 = $random(seed);
			s0 = 4'($random(seed));
			s1 = 4'($random(seed));
			fork
				wb_access(0, 1'b1, SLV1_BASE + 32'h200 + 32'(i * 4), s0, d0);
				wb_access(1, 1'b1, SLV0_BASE + 32'h300 + 32'(i * 4), s1, d1);
			join
		end

		// Reads back with mixed byte selects already merged into the copy
		for (int i = 0; i < 4; i++) begin
			fork
				wb_access(0, 1'b0, SLV0_BASE + 32'(i * 4), 4'hf, 32'h0);
				wb_access(1, 1'b0, SLV1_BASE + 32'h100 + 32'(i * 4), 4'hf, 32'h0);
			join
			fork
				wb_access(0, 1'b0, SLV1_BASE + 32'h200 + 32'(i * 4), 4'hf, 32'h0);
				wb_access(1, 1'b0, SLV0_BASE + 32'h300 + 32'(i * 4), 4'hf, 32'h0);
			join
		end

		// Unmapped addresses end in ERR
		fork
			wb_access(0, 1'b1, 32'h0000_2000, 4'hf, 32'hdead_0001);
			wb_access(1, 1'b0, 32'h8000_0010, 4'hf, 32'h0);
		join
		@(posedge clk);

		$display("Checks done: %0d transactions, %0d errors", tx_cnt, err_cnt);
		if (err_cnt == 0) begin
			$display("RESULT: PASS");
		end else begin
			$display("RESULT: FAIL");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: source/wbx_decode.sv
// Per-master address decoder that latches the chosen target and holds a one-hot request
`timescale 1ns/1ns
`default_nettype none

module wbx_decode
	import wbx_pkg::*;
(
	input  wire                                clk,
	input  wire                                rstn,
	input  wire [N_MASTERS-1:0]                m_cyc_i,
	input  wire [N_MASTERS-1:0]                m_stb_i,
	input  wire [N_MASTERS-1:0][ADDR_W-1:0]    m_adr_i,
	// Routed responses mark the end of a master's cycle
	input  wire [N_MASTERS-1:0]                m_ack_i,
	input  wire [N_MASTERS-1:0]                m_err_i,
	output wire [N_MASTERS-1:0][N_TARGETS-1:0] tgt_req_o,
	output wire [N_MASTERS-1:0][TGT_W-1:0]     tgt_sel_o
);

	// Map an address onto a target index
	function automatic logic [TGT_W-1:0] addr_to_tgt(input logic [ADDR_W-1:0] adr);
		if (adr >= SLV0_BASE && adr <= SLV0_LIMIT) begin
			return TGT_W'(0);
		end
		if (adr >= SLV1_BASE && adr <= SLV1_LIMIT) begin
			return TGT_W'(1);
		end
		// Outside both windows
		return TGT_W'(TGT_ERR);
	endfunction

	for (genvar m = 0; m < N_MASTERS; m++) begin : g_mst
		// Low when idle and high with a cycle in flight
		logic                 busy_q;
		logic [TGT_W-1:0]     sel_q;
		logic [N_TARGETS-1:0] req_q;
		logic [TGT_W-1:0]     dec_tgt;
		logic                 cyc_end;

		assign dec_tgt = addr_to_tgt(m_adr_i[m]);
		// Response seen or master gave up the cycle
		assign cyc_end = m_ack_i[m] || m_err_i[m] || !m_cyc_i[m];

		always_ff @(posedge clk) begin
			if (!rstn) begin
				busy_q <= 1'b0;
				sel_q <= '0;
				req_q <= '0;
			end else if (!busy_q) begin
				// New strobe from an idle master
				if (m_cyc_i[m] && m_stb_i[m]) begin
					busy_q <= 1'b1;
					sel_q <= dec_tgt;
					req_q <= N_TARGETS'(1) << dec_tgt;
				end
			end else if (cyc_end) begin
				// Request drops at the response edge
				busy_q <= 1'b0;
				req_q <= '0;
			end
		end

		assign tgt_req_o[m] = req_q;
		// Held after the cycle so the router still knows the last owner
		assign tgt_sel_o[m] = sel_q;

		// Latched selection must keep matching the address the master holds
		a_sel_stable: assert property (
			@(posedge clk) disable iff (!rstn)
			(busy_q && m_cyc_i[m] && m_stb_i[m]) |-> sel_q == dec_tgt
		) else $error("decode: target selection of master %0d moved while busy", m);
	end

endmodule

`default_nettype wire

// File: source/wbx_err_target.sv
// Decode-fail target answering each strobe with a single registered error
`timescale 1ns/1ns
`default_nettype none

module wbx_err_target
	import wbx_pkg::*;
(
	input  wire              clk,
	input  wire              rstn,
	input  wire              t_cyc_i,
	input  wire              t_stb_i,
	output wire              t_ack_o,
	output wire              t_err_o,
	output wire [DATA_W-1:0] t_dat_r_o
);

	logic err_q;
	// Strobe already answered, wait for it to drop
	logic done_q;

	always_ff @(posedge clk) begin
		if (!rstn) begin
			err_q <= 1'b0;
			done_q <= 1'b0;
		end else begin
			err_q <= t_cyc_i && t_stb_i && !err_q && !done_q;
			done_q <= t_stb_i && (done_q || err_q);
		end
	end

	// Never acknowledges, no read data
	assign t_ack_o = 1'b0;
	assign t_err_o = err_q;
	assign t_dat_r_o = '0;

endmodule

`default_nettype wire

// File: source/wbx_interconnect_2x2.sv
// Two-master, two-slave Wishbone classic interconnect with a decode-fail target
`timescale 1ns/1ns
`default_nettype none

module wbx_interconnect_2x2
	import wbx_pkg::*;
(
	input  wire                             clk,
	input  wire                             rstn,
	// Master side
	input  wire [N_MASTERS-1:0]             m_cyc_i,
	input  wire [N_MASTERS-1:0]             m_stb_i,
	input  wire [N_MASTERS-1:0]             m_we_i,
	input  wire [N_MASTERS-1:0][ADDR_W-1:0] m_adr_i,
	input  wire [N_MASTERS-1:0][SEL_W-1:0]  m_sel_i,
	input  wire [N_MASTERS-1:0][DATA_W-1:0] m_dat_w_i,
	output wire [N_MASTERS-1:0]             m_ack_o,
	output wire [N_MASTERS-1:0]             m_err_o,
	output wire [N_MASTERS-1:0][DATA_W-1:0] m_dat_r_o,
	// Slave side
	output wire [N_SLAVES-1:0]              s_cyc_o,
	output wire [N_SLAVES-1:0]              s_stb_o,
	output wire [N_SLAVES-1:0]              s_we_o,
	output wire [N_SLAVES-1:0][ADDR_W-1:0]  s_adr_o,
	output wire [N_SLAVES-1:0][SEL_W-1:0]   s_sel_o,
	output wire [N_SLAVES-1:0][DATA_W-1:0]  s_dat_w_o,
	input  wire [N_SLAVES-1:0]              s_ack_i,
	input  wire [N_SLAVES-1:0]              s_err_i,
	input  wire [N_SLAVES-1:0][DATA_W-1:0]  s_dat_r_i
);

	// Decoder requests, per master then per target
	wire [N_MASTERS-1:0][N_TARGETS-1:0] tgt_req;
	wire [N_MASTERS-1:0][TGT_W-1:0]     tgt_sel;
	// Same requests regrouped per target
	wire [N_TARGETS-1:0][N_MASTERS-1:0] tgt_req_col;
	// Target responses and grant state
	wire [N_TARGETS-1:0]                t_ack;
	wire [N_TARGETS-1:0]                t_err;
	wire [N_TARGETS-1:0][DATA_W-1:0]    t_dat_r;
	wire [N_TARGETS-1:0]                t_gnt;
	wire [N_TARGETS-1:0][MID_W-1:0]     t_gnt_id;

	wbx_decode u_decode (
		.clk       (clk),
		.rstn      (rstn),
		.m_cyc_i   (m_cyc_i),
		.m_stb_i   (m_stb_i),
		.m_adr_i   (m_adr_i),
		.m_ack_i   (m_ack_o),
		.m_err_i   (m_err_o),
		.tgt_req_o (tgt_req),
		.tgt_sel_o (tgt_sel)
	);

	for (genvar t = 0; t < N_TARGETS; t++) begin : g_tgt
		for (genvar m = 0; m < N_MASTERS; m++) begin : g_col
			assign tgt_req_col[t][m] = tgt_req[m][t];
		end

		if (t < N_SLAVES) begin : g_slv
			// External slave, bus goes straight out
			wbx_target_port u_port (
				.clk (clk), .rstn (rstn), .req_i (tgt_req_col[t]),
				.m_cyc_i (m_cyc_i), .m_stb_i (m_stb_i), .m_we_i (m_we_i),
				.m_adr_i (m_adr_i), .m_sel_i (m_sel_i), .m_dat_w_i (m_dat_w_i),
				.t_cyc_o (s_cyc_o[t]), .t_stb_o (s_stb_o[t]), .t_we_o (s_we_o[t]),
				.t_adr_o (s_adr_o[t]), .t_sel_o (s_sel_o[t]), .t_dat_w_o (s_dat_w_o[t]),
				.gnt_o (t_gnt[t]), .gnt_id_o (t_gnt_id[t])
			);
			assign t_ack[t] = s_ack_i[t];
			assign t_err[t] = s_err_i[t];
			assign t_dat_r[t] = s_dat_r_i[t];
		end else begin : g_err
			// Decode-fail target only looks at CYC and STB
			wire err_cyc;
			wire err_stb;

			wbx_target_port u_port (
				.clk (clk), .rstn (rstn), .req_i (tgt_req_col[t]),
				.m_cyc_i (m_cyc_i), .m_stb_i (m_stb_i), .m_we_i (m_we_i),
				.m_adr_i (m_adr_i), .m_sel_i (m_sel_i), .m_dat_w_i (m_dat_w_i),
				.t_cyc_o (err_cyc), .t_stb_o (err_stb), .t_we_o (),
				.t_adr_o (), .t_sel_o (), .t_dat_w_o (),
				.gnt_o (t_gnt[t]), .gnt_id_o (t_gnt_id[t])
			);
			wbx_err_target u_err (
				.clk (clk), .rstn (rstn), .t_cyc_i (err_cyc), .t_stb_i (err_stb),
				.t_ack_o (t_ack[t]), .t_err_o (t_err[t]), .t_dat_r_o (t_dat_r[t])
			);
		end
	end

	wbx_resp_route u_route (
		.t_ack_i    (t_ack),
		.t_err_i    (t_err),
		.t_dat_r_i  (t_dat_r),
		.t_gnt_i    (t_gnt),
		.t_gnt_id_i (t_gnt_id),
		.tgt_sel_i  (tgt_sel),
		.m_ack_o    (m_ack_o),
		.m_err_o    (m_err_o),
		.m_dat_r_o  (m_dat_r_o)
	);

endmodule

`default_nettype wire

// File: source/wbx_pkg.sv
// Wishbone 2x2 interconnect package with bus widths, port counts and the slave address map
`default_nettype none

package wbx_pkg;

	// Bus widths
	localparam int ADDR_W = 32;
	localparam int DATA_W = 32;
	// One select bit per data byte
	localparam int SEL_W = DATA_W / 8;

	// Masters and their index width
	localparam int N_MASTERS = 2;
	localparam int MID_W = $clog2(N_MASTERS);

	// External slaves
	localparam int N_SLAVES = 2;
	// Slaves plus the decode-fail target
	localparam int N_TARGETS = N_SLAVES + 1;
	localparam int TGT_W = $clog2(N_TARGETS);
	// Decode-fail target sits after the last slave
	localparam int TGT_ERR = N_SLAVES;

	// Slave 0 window, inclusive
	localparam logic [ADDR_W-1:0] SLV0_BASE = 32'h0000_0000;
	localparam logic [ADDR_W-1:0] SLV0_LIMIT = 32'h0000_0FFF;

	// Slave 1 window, inclusive
	localparam logic [ADDR_W-1:0] SLV1_BASE = 32'h0001_0000;
	localparam logic [ADDR_W-1:0] SLV1_LIMIT = 32'h0001_0FFF;

endpackage

`default_nettype wire

// File: source/wbx_resp_route.sv
// Response router steering each target's ACK, ERR and read data to its owning master
`timescale 1ns/1ns
`default_nettype none

module wbx_resp_route
	import wbx_pkg::*;
(
	input  wire [N_TARGETS-1:0]             t_ack_i,
	input  wire [N_TARGETS-1:0]             t_err_i,
	input  wire [N_TARGETS-1:0][DATA_W-1:0] t_dat_r_i,
	// Grant state of each target port
	input  wire [N_TARGETS-1:0]             t_gnt_i,
	input  wire [N_TARGETS-1:0][MID_W-1:0]  t_gnt_id_i,
	// Target chosen by each master's decoder
	input  wire [N_MASTERS-1:0][TGT_W-1:0]  tgt_sel_i,
	output logic [N_MASTERS-1:0]            m_ack_o,
	output logic [N_MASTERS-1:0]            m_err_o,
	output logic [N_MASTERS-1:0][DATA_W-1:0] m_dat_r_o
);

	// Per master, per target ownership match
	logic [N_MASTERS-1:0][N_TARGETS-1:0] own;

	always_comb begin
		for (int m = 0; m < N_MASTERS; m++) begin
			for (int t = 0; t < N_TARGETS; t++) begin
				// Master picked this target and the port granted it
				own[m][t] = (tgt_sel_i[m] == TGT_W'(t)) && t_gnt_i[t] &&
					(t_gnt_id_i[t] == MID_W'(m));
			end
		end
	end

	always_comb begin
		m_ack_o = '0;
		m_err_o = '0;
		m_dat_r_o = '0;
		for (int m = 0; m < N_MASTERS; m++) begin
			for (int t = 0; t < N_TARGETS; t++) begin
				// At most one target matches since the selection is a single index
				if (own[m][t]) begin
					m_ack_o[m] = t_ack_i[t];
					m_err_o[m] = t_err_i[t];
					m_dat_r_o[m] = t_dat_r_i[t];
				end
			end
		end
	end

	// Owning target must never answer with both ACK and ERR
	always_comb begin
		for (int m = 0; m < N_MASTERS; m++) begin
			a_ack_err: assert (!(m_ack_o[m] && m_err_o[m]))
				else $error("router: ACK and ERR together to master %0d", m);
		end
	end

endmodule

`default_nettype wire

// File: source/wbx_target_port.sv
// Target port with a round-robin master arbiter and the request mux onto the target bus
`timescale 1ns/1ns
`default_nettype none

module wbx_target_port
	import wbx_pkg::*;
(
	input  wire                             clk,
	input  wire                             rstn,
	// This target's column of the decoder requests
	input  wire [N_MASTERS-1:0]             req_i,
	input  wire [N_MASTERS-1:0]             m_cyc_i,
	input  wire [N_MASTERS-1:0]             m_stb_i,
	input  wire [N_MASTERS-1:0]             m_we_i,
	input  wire [N_MASTERS-1:0][ADDR_W-1:0] m_adr_i,
	input  wire [N_MASTERS-1:0][SEL_W-1:0]  m_sel_i,
	input  wire [N_MASTERS-1:0][DATA_W-1:0] m_dat_w_i,
	output logic                            t_cyc_o,
	output logic                            t_stb_o,
	output logic                            t_we_o,
	output logic [ADDR_W-1:0]               t_adr_o,
	output logic [SEL_W-1:0]                t_sel_o,
	output logic [DATA_W-1:0]               t_dat_w_o,
	output wire                             gnt_o,
	output wire [MID_W-1:0]                 gnt_id_o
);

	// Grant held for the owning master
	logic             gnt_q;
	// Current or last owner that also serves as the round-robin pointer
	logic [MID_W-1:0] gnt_id_q;
	// Winner of the rotating priority search
	logic             pick_vld;
	logic [MID_W-1:0] pick_id;
	logic [MID_W-1:0] cand;

	// Search starts one past the last owner
	always_comb begin
		pick_vld = 1'b0;
		pick_id = gnt_id_q;
		cand = gnt_id_q;
		for (int i = 1; i <= N_MASTERS; i++) begin
			cand = MID_W'((int'(gnt_id_q) + i) % N_MASTERS);
			if (!pick_vld && req_i[cand]) begin
				pick_vld = 1'b1;
				pick_id = cand;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (!rstn) begin
			gnt_q <= 1'b0;
			// Pointer at the last master so master 0 wins the first tie
			gnt_id_q <= MID_W'(N_MASTERS - 1);
		end else if (!gnt_q) begin
			if (pick_vld) begin
				gnt_q <= 1'b1;
				gnt_id_q <= pick_id;
			end
		end else if (!req_i[gnt_id_q]) begin
			// Port frees up one edge after the decoder clears the owner's request
			gnt_q <= 1'b0;
		end
	end

	// Forward the owner's fields or zeros when nobody holds the port
	always_comb begin
		t_cyc_o = 1'b0;
		t_stb_o = 1'b0;
		t_we_o = 1'b0;
		t_adr_o = '0;
		t_sel_o = '0;
		t_dat_w_o = '0;
		if (gnt_q) begin
			// CYC and STB cut as soon as the owner's request drops
			t_cyc_o = m_cyc_i[gnt_id_q] && req_i[gnt_id_q];
			t_stb_o = m_stb_i[gnt_id_q] && req_i[gnt_id_q];
			t_we_o = m_we_i[gnt_id_q];
			t_adr_o = m_adr_i[gnt_id_q];
			t_sel_o = m_sel_i[gnt_id_q];
			t_dat_w_o = m_dat_w_i[gnt_id_q];
		end
	end

	assign gnt_o = gnt_q;
	assign gnt_id_o = gnt_id_q;

	// Granted strobe only reaches the target inside the owner's bus cycle
	a_stb_cyc: assert property (
		@(posedge clk) disable iff (!rstn)
		t_stb_o |-> t_cyc_o
	) else $error("target port: strobe outside a bus cycle");

endmodule

`default_nettype wire

// File: src.f
source/wbx_pkg.sv
source/wbx_decode.sv
source/wbx_target_port.sv
source/wbx_err_target.sv
source/wbx_resp_route.sv
source/wbx_interconnect_2x2.sv
dv/tb_wbx.sv
